// ==== aesLite.f ====
+incdir+include
hw/aesPkg.sv
hw/aesSbox.sv
hw/aesRoundControl.sv
hw/aesRoundDatapath.sv
hw/aesOutputStage.sv
hw/aesEncTop.sv
bench/aesEncTb.sv

// ==== include/aesRefModel.svh ====
////////////////////
// FIPS-197 AES-128 encryption, slow but table free
// Byte 0 is the most significant byte of every 128-bit word
////////////////////

`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

// GF(2^8) product modulo x^8+x^4+x^3+x+1
function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
  logic [7:0] acc;
  logic [7:0] sh;
  acc = '0;
  sh  = a;
  for (int i = 0; i < 8; i++) begin
    if (b[i]) begin
      acc = acc ^ sh;
    end
    sh = {sh[6:0], 1'b0} ^ (sh[7] ? 8'h1b : 8'h00);
  end
  return acc;
endfunction

// Inverse as x^254, then the affine map
function automatic logic [7:0] subByte(input logic [7:0] x);
  logic [7:0] sq;
  logic [7:0] inv;
  sq  = x;
  inv = 8'h01;
  for (int i = 1; i < 8; i++) begin
    sq  = gfMul(sq, sq);        // x^(2^i)
    inv = gfMul(inv, sq);
  end
  return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^
         {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
endfunction

function automatic logic [127:0] aesEncrypt(input logic [127:0] key, input logic [127:0] pt);
  logic [0:15][7:0] s;
  logic [0:15][7:0] t;
  logic [0:15][7:0] k;
  logic [7:0]       rc;
  k  = key;
  s  = pt ^ key;
  rc = 8'h01;
  for (int rnd = 1; rnd <= 10; rnd++) begin
    // Key schedule, first word takes RotWord, SubWord and Rcon
    k[0] = k[0] ^ subByte(k[13]) ^ rc;
    k[1] = k[1] ^ subByte(k[14]);
    k[2] = k[2] ^ subByte(k[15]);
    k[3] = k[3] ^ subByte(k[12]);
    for (int i = 4; i < 16; i++) begin
      k[i] = k[i] ^ k[i - 4];
    end
    rc = gfMul(rc, 8'h02);
    // Row r of the state moves left by r columns
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        t[4 * c + r] = subByte(s[4 * ((c + r) % 4) + r]);
      end
    end
    s = t;
    if (rnd < 10) begin
      for (int c = 0; c < 4; c++) begin
        for (int r = 0; r < 4; r++) begin
          s[4 * c + r] = gfMul(t[4 * c + r], 8'h02) ^ gfMul(t[4 * c + (r + 1) % 4], 8'h03) ^
                         t[4 * c + (r + 2) % 4] ^ t[4 * c + (r + 3) % 4];
        end
      end
    end
    s = s ^ k;                  // AddRoundKey
  end
  return s;
endfunction

`endif

// ==== bench/aesEncTb.sv ====
////////////////////
// Self-checking testbench for aesEncTop with expected data from aesRefModel.svh
// Inputs change and outputs are read on the falling edge
////////////////////

`timescale 1ns/100ps

module aesEncTb;

  localparam int clkPeriod     = 8;
  localparam int resetCycles   = 8;
  localparam int numTests      = 6;
  localparam int blocksPerTest = 16;
  localparam int cycleLimit    = 40;   // Per block with stalls included

  logic         CLK = 1'b0;
  logic         RSTn;
  logic         EN;
  logic         Krdy;
  logic         Drdy;
  logic [127:0] Kin;
  logic [127:0] Din;
  logic [127:0] Dout;
  logic         BSY;
  logic         Kvld;
  logic         Dvld;

  logic [15:0]  lfsr;
  logic [127:0] curKey;     // Key the DUT should hold
  logic [127:0] lastDout;   // Expected Dout between blocks
  logic [127:0] rndKey;
  logic [127:0] rndBlk;
  int           errCount;
  int           testErrStart;
  int           testsFailed;

  `include "aesRefModel.svh"

  aesEncTop uut (.*);

  initial begin
    forever #(clkPeriod / 2) CLK = ~CLK;
  end

  ////////////////////
  // Helpers

  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // x^16+x^14+x^13+x^11+1
  endfunction

  task automatic takeBits(input int n, output logic [127:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr);
      v    = {v[126:0], lfsr[0]};
    end
  endtask

  task automatic checkValue(input string name, input logic [127:0] got,
                            input logic [127:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      errCount++;
    end
  endtask

  task automatic finishTest(input string name);
    if (errCount == testErrStart) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errCount - testErrStart);
      testsFailed++;
    end
    testErrStart = errCount;
  endtask

  task automatic loadKey(input logic [127:0] key, input bit stall);
    Kin  = key;
    Krdy = 1'b1;
    EN   = 1'b1;
    @(negedge CLK);
    checkValue("Kvld", Kvld, 1);
    checkValue("BSY", BSY, 0);
    Krdy = 1'b0;
    if (stall) begin
      EN = 1'b0;
      @(negedge CLK);
      checkValue("Kvld", Kvld, 1);   // Held while stalled
      EN = 1'b1;
    end
    @(negedge CLK);
    checkValue("Kvld", Kvld, 0);
    curKey = key;
  endtask

  // Counts enabled edges from the one that samples Drdy
  task automatic encryptBlock(input logic [127:0] blk, input bit stall, input bit noise);
    logic [127:0] expCt;
    logic [127:0] rnd;
    int           enCount;
    int           cycles;
    bit           enPrev;
    expCt   = aesEncrypt(curKey, blk);
    Din     = blk;
    Drdy    = 1'b1;
    EN      = 1'b1;
    enPrev  = 1'b1;
    enCount = -1;
    cycles  = 0;
    while (enCount < 10 && cycles < cycleLimit) begin
      @(negedge CLK);
      cycles++;
      if (enPrev) begin
        enCount++;
      end
      checkValue("BSY", BSY, enCount < 10);
      checkValue("Dvld", Dvld, enCount == 10);
      checkValue("Kvld", Kvld, 0);
      if (enCount < 10) begin
        checkValue("Dout", Dout, lastDout);
        Drdy = 1'b0;
        if (noise) begin
          takeBits(2, rnd);
          Krdy = rnd[1];
          Drdy = rnd[0];
          takeBits(128, rnd);
          Kin = rnd;
          takeBits(128, rnd);
          Din = rnd;
        end
        if (stall) begin
          takeBits(2, rnd);
          EN = |rnd[1:0];   // High three times in four
        end
        enPrev = EN;
      end
    end
    assert (enCount == 10) else begin
      $display("Block did not finish within %0d cycles at %0t ns", cycleLimit, $time);
      errCount++;
    end
    checkValue("Dout", Dout, expCt);
    lastDout = expCt;
    Krdy     = 1'b0;
    Drdy     = 1'b0;
    if (stall) begin
      EN = 1'b0;
      @(negedge CLK);
      checkValue("Dvld", Dvld, 1);   // Pulse held by the stall
      checkValue("Dout", Dout, expCt);
    end
    EN = 1'b1;
    @(negedge CLK);
    checkValue("Dvld", Dvld, 0);
  endtask

  ////////////////////
  // Test sequence

  initial begin
    lfsr         = 16'd94;
    errCount     = 0;
    testErrStart = 0;
    testsFailed  = 0;
    curKey       = '0;
    lastDout     = '0;
    RSTn = 1'b0;
    EN   = 1'b0;
    Krdy = 1'b0;
    Drdy = 1'b0;
    Kin  = '0;
    Din  = '0;
    repeat (resetCycles) @(negedge CLK);
    RSTn = 1'b1;

    checkValue("BSY", BSY, 0);
    checkValue("Kvld", Kvld, 0);
    checkValue("Dvld", Dvld, 0);
    checkValue("Dout", Dout, 0);
    loadKey(128'h000102030405060708090a0b0c0d0e0f, 1'b0);
    encryptBlock(128'h00112233445566778899aabbccddeeff, 1'b0, 1'b0);
    checkValue("Dout", Dout, 128'h69c4e0d86a7b0430d8cdb78070b4c55a);   // FIPS-197 C.1
    finishTest("reset and known vector");

    repeat (4) begin
      takeBits(128, rndKey);
      loadKey(rndKey, 1'b0);
    end
    finishTest("key valid pulse");

    repeat (blocksPerTest) begin
      takeBits(128, rndKey);
      takeBits(128, rndBlk);
      loadKey(rndKey, 1'b0);
      encryptBlock(rndBlk, 1'b0, 1'b0);
    end
    finishTest("random keys and blocks");

    repeat (4) begin
      takeBits(128, rndKey);
      loadKey(rndKey, 1'b0);
      repeat (4) begin
        takeBits(128, rndBlk);
        encryptBlock(rndBlk, 1'b0, 1'b0);
      end
    end
    finishTest("several blocks per key");

    repeat (blocksPerTest / 2) begin
      takeBits(128, rndKey);
      takeBits(128, rndBlk);
      loadKey(rndKey, 1'b0);
      encryptBlock(rndBlk, 1'b0, 1'b1);
    end
    finishTest("strobes while busy");

    repeat (blocksPerTest / 2) begin
      takeBits(128, rndKey);
      takeBits(128, rndBlk);
      loadKey(rndKey, 1'b1);
      encryptBlock(rndBlk, 1'b1, 1'b0);
    end
    finishTest("enable stalls");

    $display("tests %0d, tests with errors %0d, failed checks %0d",
             numTests, testsFailed, errCount);
    if (errCount == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #((numTests * blocksPerTest * 20 + resetCycles) * clkPeriod);
    $display("Run stopped because the tests did not finish in time");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== hw/aesEncTop.sv ====
////////////////////
// Iterative AES-128 encryption, 10 cycles per block
// Data before any key load uses the all-zero key
////////////////////

`timescale 1ns/100ps

module aesEncTop (
  input  logic                          CLK,
  input  logic                          RSTn,
  input  logic                          EN,
  input  logic                          Krdy,
  input  logic                          Drdy,
  input  logic [aesPkg::blockBits-1:0]  Kin,
  input  logic [aesPkg::blockBits-1:0]  Din,
  output aesPkg::aesState               Dout,
  output logic                          BSY,
  output logic                          Kvld,
  output logic                          Dvld
);

  import aesPkg::*;

  logic                 keyLoad;
  logic                 blockStart;
  logic                 roundStep;
  logic                 finalRound;
  logic [numRounds-1:0] roundSel;
  aesState              nextState;   // Combinational round result

  aesRoundControl sequencer (
    .CLK        (CLK),
    .RSTn       (RSTn),
    .EN         (EN),
    .Krdy       (Krdy),
    .Drdy       (Drdy),
    .BSY        (BSY),
    .keyLoad    (keyLoad),
    .blockStart (blockStart),
    .roundStep  (roundStep),
    .finalRound (finalRound),
    .roundSel   (roundSel)
  );

  aesRoundDatapath datapath (
    .CLK        (CLK),
    .RSTn       (RSTn),
    .EN         (EN),
    .Kin        (Kin),
    .Din        (Din),
    .keyLoad    (keyLoad),
    .blockStart (blockStart),
    .roundStep  (roundStep),
    .finalRound (finalRound),
    .roundSel   (roundSel),
    .nextState  (nextState)
  );

  aesOutputStage outStage (
    .CLK        (CLK),
    .RSTn       (RSTn),
    .EN         (EN),
    .nextState  (nextState),
    .keyLoad    (keyLoad),
    .finalRound (finalRound),
    .Dout       (Dout),
    .Kvld       (Kvld),
    .Dvld       (Dvld)
  );

endmodule

// ==== hw/aesOutputStage.sv ====
////////////////////
// Dout holds until the next block completes
// Kvld and Dvld are one enabled cycle wide
////////////////////

`timescale 1ns/100ps

module aesOutputStage (
  input  logic             CLK,
  input  logic             RSTn,
  input  logic             EN,
  input  aesPkg::aesState  nextState,
  input  logic             keyLoad,
  input  logic             finalRound,
  output aesPkg::aesState  Dout,
  output logic             Kvld,
  output logic             Dvld
);

  always_ff @(posedge CLK) begin
    if (!RSTn) begin
      Dout <= '0;
      Kvld <= 1'b0;
      Dvld <= 1'b0;
    end else if (EN) begin
      Kvld <= keyLoad;      // Every accepted key
      Dvld <= finalRound;   // Ciphertext ready
      if (finalRound) begin
        Dout <= nextState;  // Round-10 result
      end
    end
  end

endmodule

// ==== hw/aesPkg.sv ====
////////////////////
// AES-128 only. Block, key and round count are fixed
// Byte 0 and column 0 sit in the most significant bits
////////////////////

package aesPkg;

  localparam int blockBits = 128;  // State, key and round key
  localparam int wordBits  = 32;   // One column
  localparam int numRounds = 10;

  // Two views of one state word
  typedef union packed {
    logic [0:15][7:0]         bytes;  // S-box array and ShiftRows
    logic [0:3][wordBits-1:0] cols;   // MixColumns and key words
  } aesState;

  // Round constants, entry 0 belongs to round 1
  localparam logic [numRounds-1:0][7:0] roundConTable = {
    8'h36, 8'h1b, 8'h80, 8'h40, 8'h20,
    8'h10, 8'h08, 8'h04, 8'h02, 8'h01
  };

  // One-hot selector to Rcon byte, zero when idle
  function automatic logic [7:0] roundCon(input logic [numRounds-1:0] sel);
    logic [7:0] rc;
    rc = '0;
    for (int i = 0; i < numRounds; i++) begin
      if (sel[i]) begin
        rc = rc | roundConTable[i];
      end
    end
    return rc;
  endfunction

endpackage

// ==== hw/aesRoundControl.sv ====
////////////////////
// Strobes are sampled only while idle, Krdy before Drdy
// EN low freezes the sequencer
////////////////////

`timescale 1ns/100ps

module aesRoundControl (
  input  logic                          CLK,
  input  logic                          RSTn,
  input  logic                          EN,
  input  logic                          Krdy,
  input  logic                          Drdy,
  output logic                          BSY,
  output logic                          keyLoad,
  output logic                          blockStart,
  output logic                          roundStep,
  output logic                          finalRound,
  output logic [aesPkg::numRounds-1:0]  roundSel
);

  import aesPkg::*;

  logic advance;   // Move the selector on by one round

  ////////////////////
  // Controls for the datapath

  assign keyLoad    = !BSY && Krdy;
  assign blockStart = !BSY && !Krdy && Drdy;
  assign roundStep  = BSY;
  // Selector wraps back to round 1 position for the last round
  assign finalRound = BSY && roundSel[0];
  assign advance    = blockStart || (roundStep && !finalRound);

  ////////////////////
  // Busy flag and one-hot round register

  always_ff @(posedge CLK) begin
    if (!RSTn) begin
      BSY      <= 1'b0;
      roundSel <= numRounds'(1);   // Round 1
    end else if (EN) begin
      if (blockStart) begin
        BSY <= 1'b1;
      end else if (finalRound) begin
        BSY <= 1'b0;
      end
      if (advance) begin
        roundSel <= {roundSel[numRounds-2:0], roundSel[numRounds-1]};
      end
    end
  end

endmodule

// ==== hw/aesRoundDatapath.sv ====
////////////////////
// One AES-128 round per enabled cycle, key expanded on the fly
// Key registers clear to zero on reset, the state register does not
////////////////////

`timescale 1ns/100ps

module aesRoundDatapath (
  input  logic                          CLK,
  input  logic                          RSTn,
  input  logic                          EN,
  input  logic [aesPkg::blockBits-1:0]  Kin,
  input  logic [aesPkg::blockBits-1:0]  Din,
  input  logic                          keyLoad,
  input  logic                          blockStart,
  input  logic                          roundStep,
  input  logic                          finalRound,
  input  logic [aesPkg::numRounds-1:0]  roundSel,
  output aesPkg::aesState               nextState
);

  import aesPkg::*;

  localparam int numBytes = blockBits / 8;

  aesState stateReg;            // Round state
  aesState cipherKey;           // Stored cipher key
  aesState workKey;             // Key of the current round
  aesState shifted;             // After ShiftRows
  aesState mixed;               // After MixColumns
  aesState nextKey;
  logic [0:numBytes-1][7:0] subOut;   // After SubBytes
  logic [0:3][7:0]          keySub;   // SubWord(RotWord(w3))

  function automatic logic [7:0] xtime(input logic [7:0] v);
    return {v[6:0], 1'b0} ^ (v[7] ? 8'h1b : 8'h00);
  endfunction

  function automatic logic [0:3][7:0] mixColumn(input logic [0:3][7:0] col);
    logic [7:0] t;
    t = col[0] ^ col[1] ^ col[2] ^ col[3];
    return {col[0] ^ t ^ xtime(col[0] ^ col[1]),
            col[1] ^ t ^ xtime(col[1] ^ col[2]),
            col[2] ^ t ^ xtime(col[2] ^ col[3]),
            col[3] ^ t ^ xtime(col[3] ^ col[0])};
  endfunction

  ////////////////////
  // S-boxes

  for (genvar i = 0; i < numBytes; i++) begin : stateSbox
    aesSbox sbox (.x(stateReg.bytes[i]), .y(subOut[i]));
  end

  // Last key word, rotated by one byte
  for (genvar k = 0; k < 4; k++) begin : keySbox
    aesSbox sbox (.x(workKey.bytes[12 + ((k + 1) % 4)]), .y(keySub[k]));
  end

  ////////////////////
  // Round function

  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shifted.bytes[4 * c + r] = subOut[4 * ((c + r) % 4) + r];  // Row r rotates left by r
      end
    end
    for (int c = 0; c < 4; c++) begin
      mixed.cols[c] = mixColumn(shifted.cols[c]);
    end
    nextState = (finalRound ? shifted : mixed) ^ workKey;  // No MixColumns in round 10
  end

  // Next round key
  always_comb begin
    nextKey.cols[0] = workKey.cols[0] ^ keySub ^ {roundCon(roundSel), {(wordBits - 8){1'b0}}};
    for (int w = 1; w < 4; w++) begin
      nextKey.cols[w] = workKey.cols[w] ^ nextKey.cols[w - 1];
    end
  end

  ////////////////////
  // Registers

  always_ff @(posedge CLK) begin
    if (!RSTn) begin
      cipherKey <= '0;
      workKey   <= '0;
    end else if (EN) begin
      if (keyLoad) begin
        cipherKey <= Kin;
        workKey   <= Kin;
      end else if (blockStart) begin
        workKey <= nextKey;                            // Round-1 key
      end else if (roundStep) begin
        workKey <= finalRound ? cipherKey : nextKey;   // Rewind for the next block
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (EN) begin
      if (blockStart) begin
        stateReg <= Din ^ cipherKey;   // Initial AddRoundKey
      end else if (roundStep) begin
        stateReg <= nextState;
      end
    end
  end

endmodule

// ==== hw/aesSbox.sv ====
////////////////////
// Forward S-box only, purely combinational
// Inversion done in GF(((2^2)^2)^2)
////////////////////

`timescale 1ns/100ps

module aesSbox (
  input  logic [7:0] x,
  output logic [7:0] y
);

  // Basis change into the composite field, row for bit 7 first
  localparam logic [7:0][7:0] mapIn = {
    8'hA0, 8'hDE, 8'hAC, 8'hAE, 8'hC6, 8'h9E, 8'h52, 8'h43
  };
  // Back to polynomial basis merged with the affine matrix
  localparam logic [7:0][7:0] mapOut = {
    8'h8C, 8'hF0, 8'h84, 8'h93, 8'h07, 8'h7D, 8'h81, 8'hC7
  };
  localparam logic [7:0] affineConst = 8'h63;

  logic [7:0] a;         // Composite-field input
  logic [7:0] b;         // Composite-field inverse
  logic [3:0] hi;
  logic [3:0] lo;
  logic [3:0] delta;     // Norm of a over GF(2^4)
  logic [3:0] deltaInv;

  ////////////////////
  // GF(2^2) and GF(2^4) arithmetic

  function automatic logic [2:0] spread2(input logic [1:0] p);
    return {p[1], p[1] ^ p[0], p[0]};
  endfunction

  function automatic logic [1:0] gf4Mul(input logic [1:0] p, input logic [1:0] q);
    logic [2:0] r;
    r = spread2(p) & spread2(q);  // Three AND terms
    return {r[0] ^ r[1], r[0] ^ r[2]};
  endfunction

  function automatic logic [3:0] gf16Mul(input logic [3:0] p, input logic [3:0] q);
    logic [1:0] loProd;
    logic [1:0] hiProd;
    logic [1:0] midProd;
    loProd  = gf4Mul(p[1:0], q[1:0]);
    hiProd  = gf4Mul(p[3:2], q[3:2]);
    midProd = gf4Mul(p[3:2] ^ p[1:0], q[3:2] ^ q[1:0]);  // Karatsuba middle term
    return {midProd ^ loProd, loProd ^ {hiProd[1] ^ hiProd[0], hiProd[1]}};
  endfunction

  function automatic logic [3:0] gf16Inv(input logic [3:0] u);
    logic [1:0] d;
    logic [1:0] dInv;
    d    = gf4Mul(u[1:0], u[1:0] ^ u[3:2]) ^ {u[2], u[3]};  // Norm in GF(2^2)
    dInv = {d[1], d[1] ^ d[0]};                             // GF(2^2) inverse is linear
    return {gf4Mul(dInv, u[3:2]), gf4Mul(dInv, u[3:2] ^ u[1:0])};
  endfunction

  ////////////////////
  // Map, invert, map back

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      a[i] = ^(x & mapIn[i]);
    end
    hi = a[7:4];
    lo = a[3:0];
    // lo*(lo+hi) plus lambda*hi^2
    delta = gf16Mul(lo, lo ^ hi) ^
            {hi[0] ^ hi[1] ^ hi[2], hi[0] ^ hi[3], hi[3], hi[2] ^ hi[3]};
    deltaInv = gf16Inv(delta);
    b = {gf16Mul(deltaInv, hi), gf16Mul(deltaInv, hi ^ lo)};
    for (int i = 0; i < 8; i++) begin
      y[i] = ^(b & mapOut[i]) ^ affineConst[i];
    end
  end

endmodule
